// File: hw/hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none
module hazardDetect (
    input  logic              readsRs,
    input  logic              readsB,
    input  issuePkg::regIdx_t srcRs,
    input  issuePkg::regIdx_t srcB,
    input  logic              regWrtD,
    input  issuePkg::regIdx_t wrtRegD,
    input  issuePkg::wbSel_t  wbSelD,
    input  logic              regWrtX,
    input  issuePkg::regIdx_t wrtRegX,
    input  issuePkg::wbSel_t  wbSelX,
    input  logic              regWrtM,
    input  issuePkg::regIdx_t wrtRegM,
    output logic              hazard,
    output issuePkg::fwCtrl_t fwCntrlA,
    output issuePkg::fwCtrl_t fwCntrlB
);
    import issuePkg::*;

    logic hazA;
    logic hazB;

    // youngest matching writer wins for one source register
    function automatic fwCtrl_t resolveSrc(
        input  logic    reads,
        input  regIdx_t src,
        output logic    stall
    );
        logic    hitD;
        logic    hitX;
        logic    hitM;
        fwCtrl_t code;
        hitD  = reads && regWrtD && (src == wrtRegD);
        hitX  = reads && regWrtX && (src == wrtRegX);
        hitM  = reads && regWrtM && (src == wrtRegM);
        stall = 1'b0;
        code  = '0;
        if (hitD) begin
            // load data is not ready for ex-to-ex forwarding
            if (wbSelD == WB_MEM) begin
                stall = 1'b1;
            end else begin
                code = {1'b1, 1'b0, wbSelD};
            end
        end else if (hitX) begin
            code = {1'b1, 1'b1, wbSelX};
        end else if (hitM) begin
            // no path from the memory slot so wait for the register file
            stall = 1'b1;
        end
        return code;
    endfunction

    always_comb begin
        fwCntrlA = resolveSrc(readsRs, srcRs, hazA);
        fwCntrlB = resolveSrc(readsB, srcB, hazB);
        hazard   = hazA | hazB;
    end

endmodule
`default_nettype wire

// File: hw/instDecode.sv
`timescale 1ns/1ps
`default_nettype none
module instDecode (
    input  issuePkg::instWord_t fetchInst,
    output logic                readsRs,
    output logic                readsB,
    output issuePkg::regIdx_t   srcRs,
    output issuePkg::regIdx_t   srcB,
    output logic                writesReg,
    output issuePkg::regIdx_t   destReg,
    output issuePkg::wbSel_t    destSel,
    output logic                isControl,
    output logic                isHalt
);
    import issuePkg::*;

    opcode_t opcode;
    regIdx_t fieldRs;
    regIdx_t fieldB;
    regIdx_t fieldRd;

    assign opcode  = fetchInst[15:11];
    assign fieldRs = fetchInst[10:8];
    assign fieldB  = fetchInst[7:5];
    assign fieldRd = fetchInst[4:2];

    // only the read flags depend on the opcode
    assign srcRs = fieldRs;
    assign srcB  = fieldB;

    always_comb begin
        // immediate forms read rs and write field B from the alu
        readsRs   = 1'b1;
        readsB    = 1'b0;
        writesReg = 1'b1;
        destReg   = fieldB;
        destSel   = WB_ALU;
        isControl = 1'b0;
        isHalt    = 1'b0;
        case (opcode[4:2])
            PFX_SET: begin
                readsB  = 1'b1;
                destReg = fieldRd;
            end
            PFX_BRANCH: begin
                writesReg = 1'b0;
                isControl = 1'b1;
            end
            PFX_JUMP: begin
                // bit 0 selects the register forms and bit 1 the linking ones
                readsRs   = opcode[0];
                writesReg = opcode[1];
                destReg   = LINK_REG;
                destSel   = WB_LINK;
                isControl = 1'b1;
            end
            default: begin
                case (opcode)
                    OP_ST: begin
                        readsB    = 1'b1;
                        writesReg = 1'b0;
                    end
                    // store with update writes the base back
                    OP_STU: begin
                        readsB  = 1'b1;
                        destReg = fieldRs;
                    end
                    OP_ARITH, OP_BITOP: begin
                        readsB  = 1'b1;
                        destReg = fieldRd;
                    end
                    OP_LD: begin
                        destSel = WB_MEM;
                    end
                    OP_LBI: begin
                        readsRs = 1'b0;
                        destReg = fieldRs;
                        destSel = WB_IMM;
                    end
                    OP_HALT, OP_NOP, OP_SIIC, OP_RTI: begin
                        readsRs   = 1'b0;
                        writesReg = 1'b0;
                        isHalt    = (opcode == OP_HALT);
                    end
                    // remaining opcodes keep the immediate-form defaults
                    default: ;
                endcase
            end
        endcase
    end

endmodule
`default_nettype wire

// File: hw/issuePkg.sv
package issuePkg;

    // one fetched instruction and its fields
    typedef logic [15:0] instWord_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [2:0]  regIdx_t;

    // where a writer's result comes from at writeback
    typedef logic [1:0]  wbSel_t;

    // {forward, from execute slot, source wbSel}
    typedef logic [3:0]  fwCtrl_t;

    typedef enum logic {
        SEQ_RUN,
        SEQ_HALTED
    } seqState_t;

    localparam wbSel_t WB_LINK = 2'b00;
    localparam wbSel_t WB_MEM  = 2'b01;
    localparam wbSel_t WB_ALU  = 2'b10;
    localparam wbSel_t WB_IMM  = 2'b11;

    // exact opcodes the decoder treats specially
    localparam opcode_t OP_HALT  = 5'b00000;
    localparam opcode_t OP_NOP   = 5'b00001;
    localparam opcode_t OP_SIIC  = 5'b00010;
    localparam opcode_t OP_RTI   = 5'b00011;
    localparam opcode_t OP_ST    = 5'b10000;
    localparam opcode_t OP_LD    = 5'b10001;
    localparam opcode_t OP_STU   = 5'b10011;
    localparam opcode_t OP_LBI   = 5'b11000;
    localparam opcode_t OP_BITOP = 5'b11010;
    localparam opcode_t OP_ARITH = 5'b11011;

    // upper three opcode bits of the grouped instructions
    localparam logic [2:0] PFX_SET    = 3'b111;
    localparam logic [2:0] PFX_BRANCH = 3'b011;
    localparam logic [2:0] PFX_JUMP   = 3'b001;

    // jal/jalr return address lands here
    localparam regIdx_t LINK_REG = 3'd7;

    localparam instWord_t NOP_INST = {OP_NOP, 11'b0};

    // cycles held off after a branch or jump issues
    localparam int unsigned SHADOW_CYCLES = 4;

endpackage

// File: hw/issueSequencer.sv
`timescale 1ns/1ps
`default_nettype none
module issueSequencer (
    input  logic                clk,
    input  logic                reset,
    input  issuePkg::instWord_t fetchInst,
    input  logic                hazard,
    input  logic                shadowBusy,
    input  logic                isControl,
    input  logic                isHalt,
    output issuePkg::instWord_t issueInst,
    output logic                pcNop,
    output logic                issued,
    output logic                issueControl,
    output logic                issueHalt
);
    import issuePkg::*;

    seqState_t state;
    logic      blocked;

    // halted is sticky until the next reset
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_RUN;
        end else if (issueHalt) begin
            state <= SEQ_HALTED;
        end
    end

    // any of these turns the slot into a nop and holds the pc
    assign blocked = reset || (state == SEQ_HALTED) || shadowBusy || hazard;

    assign pcNop     = blocked;
    assign issueInst = blocked ? NOP_INST : fetchInst;
    assign issued    = ~blocked;

    // strobes for the writer record and the shadow timer
    assign issueControl = issued & isControl;
    assign issueHalt    = issued & isHalt;

endmodule
`default_nettype wire

// File: hw/issueStage.sv
`timescale 1ns/1ps
`default_nettype none
module issueStage (
    input  logic                clk,
    input  logic                reset,
    input  issuePkg::instWord_t fetchInst,
    output issuePkg::instWord_t issueInst,
    output logic                pcNop,
    output issuePkg::fwCtrl_t   fwCntrlA,
    output issuePkg::fwCtrl_t   fwCntrlB
);
    import issuePkg::*;

    // decoded view of the fetched word
    logic    readsRs;
    logic    readsB;
    regIdx_t srcRs;
    regIdx_t srcB;
    logic    writesReg;
    regIdx_t destReg;
    wbSel_t  destSel;
    logic    isControl;
    logic    isHalt;

    // writers in flight
    logic    regWrtD;
    regIdx_t wrtRegD;
    wbSel_t  wbSelD;
    logic    regWrtX;
    regIdx_t wrtRegX;
    wbSel_t  wbSelX;
    logic    regWrtM;
    regIdx_t wrtRegM;

    logic hazard;
    logic shadowBusy;
    logic issued;
    logic issueControl;

    instDecode instDecode_i (
        .fetchInst (fetchInst),
        .readsRs   (readsRs),
        .readsB    (readsB),
        .srcRs     (srcRs),
        .srcB      (srcB),
        .writesReg (writesReg),
        .destReg   (destReg),
        .destSel   (destSel),
        .isControl (isControl),
        .isHalt    (isHalt)
    );

    // memory-slot source is never forwarded so it stays open here
    writerPipeline writerPipeline_i (
        .clk       (clk),
        .reset     (reset),
        .issued    (issued),
        .writesReg (writesReg),
        .destReg   (destReg),
        .destSel   (destSel),
        .regWrtD   (regWrtD),
        .wrtRegD   (wrtRegD),
        .wbSelD    (wbSelD),
        .regWrtX   (regWrtX),
        .wrtRegX   (wrtRegX),
        .wbSelX    (wbSelX),
        .regWrtM   (regWrtM),
        .wrtRegM   (wrtRegM),
        .wbSelM    ()
    );

    hazardDetect hazardDetect_i (
        .readsRs  (readsRs),
        .readsB   (readsB),
        .srcRs    (srcRs),
        .srcB     (srcB),
        .regWrtD  (regWrtD),
        .wrtRegD  (wrtRegD),
        .wbSelD   (wbSelD),
        .regWrtX  (regWrtX),
        .wrtRegX  (wrtRegX),
        .wbSelX   (wbSelX),
        .regWrtM  (regWrtM),
        .wrtRegM  (wrtRegM),
        .hazard   (hazard),
        .fwCntrlA (fwCntrlA),
        .fwCntrlB (fwCntrlB)
    );

    shadowTimer shadowTimer_i (
        .clk          (clk),
        .reset        (reset),
        .issueControl (issueControl),
        .shadowBusy   (shadowBusy)
    );

    // halt strobe only feeds the sequencer's own state
    issueSequencer issueSequencer_i (
        .clk          (clk),
        .reset        (reset),
        .fetchInst    (fetchInst),
        .hazard       (hazard),
        .shadowBusy   (shadowBusy),
        .isControl    (isControl),
        .isHalt       (isHalt),
        .issueInst    (issueInst),
        .pcNop        (pcNop),
        .issued       (issued),
        .issueControl (issueControl),
        .issueHalt    ()
    );

endmodule
`default_nettype wire

// File: hw/shadowTimer.sv
`timescale 1ns/1ps
`default_nettype none
module shadowTimer (
    input  logic clk,
    input  logic reset,
    input  logic issueControl,
    output logic shadowBusy
);
    import issuePkg::*;

    logic [2:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (issueControl) begin
            count <= 3'(SHADOW_CYCLES);
        end else if (count != 3'd0) begin
            count <= count - 3'd1;
        end
    end

    // busy from the cycle after the control issue
    assign shadowBusy = (count != 3'd0);

endmodule
`default_nettype wire

// File: hw/writerPipeline.sv
`timescale 1ns/1ps
`default_nettype none
module writerPipeline (
    input  logic              clk,
    input  logic              reset,
    input  logic              issued,
    input  logic              writesReg,
    input  issuePkg::regIdx_t destReg,
    input  issuePkg::wbSel_t  destSel,
    output logic              regWrtD,
    output issuePkg::regIdx_t wrtRegD,
    output issuePkg::wbSel_t  wbSelD,
    output logic              regWrtX,
    output issuePkg::regIdx_t wrtRegX,
    output issuePkg::wbSel_t  wbSelX,
    output logic              regWrtM,
    output issuePkg::regIdx_t wrtRegM,
    output issuePkg::wbSel_t  wbSelM
);

    // write enables decide whether a slot holds a writer at all
    always_ff @(posedge clk) begin
        if (reset) begin
            regWrtD <= 1'b0;
            regWrtX <= 1'b0;
            regWrtM <= 1'b0;
        end else begin
            // a nop in place of the fetched word carries no writer
            regWrtD <= issued & writesReg;
            regWrtX <= regWrtD;
            regWrtM <= regWrtX;
        end
    end

    // writer register and source for each slot
    always_ff @(posedge clk) begin
        wrtRegD <= destReg;
        wbSelD  <= destSel;
        wrtRegX <= wrtRegD;
        wbSelX  <= wbSelD;
        wrtRegM <= wrtRegX;
        wbSelM  <= wbSelX;
    end

endmodule
`default_nettype wire

// File: issueStage.f
hw/issuePkg.sv
hw/instDecode.sv
hw/writerPipeline.sv
hw/hazardDetect.sv
hw/shadowTimer.sv
hw/issueSequencer.sv
hw/issueStage.sv
tb/issueStage_assertions.sv
tb/issueStage_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module issueStage_tb \
    -f issueStage.f -o issueStage_sim

result=$(./obj_dir/issueStage_sim 2>&1 || true)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

// File: tb/issueStage_assertions.sv
`timescale 1ns/1ps
module issueStage_assertions (
    input logic                clk,
    input logic                reset,
    input issuePkg::instWord_t fetchInst,
    input issuePkg::instWord_t issueInst,
    input logic                pcNop,
    input issuePkg::fwCtrl_t   fwCntrlA,
    input issuePkg::fwCtrl_t   fwCntrlB
);
    import issuePkg::*;

    logic controlIssued;

    // branch or jump leaving the stage
    assign controlIssued = !pcNop &&
        ((fetchInst[15:13] == PFX_BRANCH) || (fetchInst[15:13] == PFX_JUMP));

    passThrough: assert property (@(posedge clk) !pcNop |-> (issueInst == fetchInst))
        else $error("issueInst differs from fetchInst with pcNop low");

    nopOnHold: assert property (@(posedge clk) pcNop |-> (issueInst == NOP_INST))
        else $error("issueInst is not the nop word with pcNop high");

    // four cycles of shadow after any issued control word
    shadowHold: assert property (@(posedge clk) disable iff (reset)
        ($past(controlIssued, 1) || $past(controlIssued, 2) ||
         $past(controlIssued, 3) || $past(controlIssued, 4)) |-> pcNop)
        else $error("pcNop low inside the control shadow");

    // no stray slot or sel bits without the forward bit
    cleanCodeA: assert property (@(posedge clk) !fwCntrlA[3] |-> (fwCntrlA == '0))
        else $error("operand A code has bits set without forward");

    cleanCodeB: assert property (@(posedge clk) !fwCntrlB[3] |-> (fwCntrlB == '0))
        else $error("operand B code has bits set without forward");

endmodule

bind issueStage issueStage_assertions issueStage_assertions_i (.*);

// File: tb/issueStage_tb.sv
`timescale 1ns/1ps
module issueStage_tb;
    import issuePkg::*;

    localparam int TIMEOUT_CYCLES = 1000;

    logic      clk = 1'b1;
    logic      reset;
    instWord_t fetchInst;
    instWord_t issueInst;
    logic      pcNop;
    fwCtrl_t   fwCntrlA;
    fwCtrl_t   fwCntrlB;

    integer seed;
    int     cycleCount = 0;

    issueStage issueStage_i (
        .clk       (clk),
        .reset     (reset),
        .fetchInst (fetchInst),
        .issueInst (issueInst),
        .pcNop     (pcNop),
        .fwCntrlA  (fwCntrlA),
        .fwCntrlB  (fwCntrlB)
    );

    // 10 ns period with a falling first edge
    always #5 clk = ~clk;

    // run limit well above the length of the tests
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "run limit reached");
        end
    end

    task automatic checkInst(input instWord_t got, input instWord_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s issueInst %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "issue word check");
        end
    endtask

    task automatic checkFw(input fwCtrl_t got, input fwCtrl_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s code %b, expected %b", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "forwarding code check");
        end
    endtask

    task automatic checkStall(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s pcNop %b, expected %b", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "stall check");
        end
    endtask

    // {opcode, rs, field B, rdR, two low bits}
    function automatic instWord_t makeInst(
        input opcode_t op,
        input regIdx_t rs,
        input regIdx_t fb,
        input regIdx_t rd
    );
        return {op, rs, fb, rd, 2'b00};
    endfunction

    // forward bit, slot bit (execute = 1), writer source
    function automatic fwCtrl_t forwardCode(input logic fromExec, input wbSel_t sel);
        return {1'b1, fromExec, sel};
    endfunction

    function automatic regIdx_t randReg();
        logic [31:0] raw;
        raw = $random(seed);
        return raw[2:0];
    endfunction

    function automatic instWord_t randWord();
        logic [31:0] raw;
        raw = $random(seed);
        return raw[15:0];
    endfunction

    // random register different from both a and b
    function automatic regIdx_t pickOther(input regIdx_t a, input regIdx_t b);
        regIdx_t r;
        r = randReg();
        while (r == a || r == b) begin
            r = randReg();
        end
        return r;
    endfunction

    // one falling-edge-to-falling-edge cycle that must issue w
    task automatic driveIssued(
        input instWord_t w,
        input fwCtrl_t   expA,
        input fwCtrl_t   expB,
        input string     what
    );
        fetchInst = w;
        // sample just before the rising edge
        #4;
        checkStall(pcNop, 1'b0, what);
        checkInst(issueInst, w, what);
        checkFw(fwCntrlA, expA, {what, " operand A"});
        checkFw(fwCntrlB, expB, {what, " operand B"});
        @(negedge clk);
    endtask

    // one cycle where w is held back and a nop goes out
    task automatic holdStalled(
        input instWord_t w,
        input fwCtrl_t   expA,
        input fwCtrl_t   expB,
        input string     what
    );
        fetchInst = w;
        #4;
        checkStall(pcNop, 1'b1, what);
        checkInst(issueInst, NOP_INST, what);
        checkFw(fwCntrlA, expA, {what, " operand A"});
        checkFw(fwCntrlB, expB, {what, " operand B"});
        @(negedge clk);
    endtask

    // three nops push every writer out of the record
    task automatic drainWriters();
        repeat (3) begin
            driveIssued(NOP_INST, '0, '0, "drain nop");
        end
    endtask

    // three reset edges with a live instruction on fetch
    task automatic applyReset();
        reset = 1'b1;
        fetchInst = makeInst(OP_ARITH, randReg(), randReg(), randReg());
        repeat (3) begin
            #4;
            checkStall(pcNop, 1'b1, "during reset");
            checkInst(issueInst, NOP_INST, "during reset");
            @(negedge clk);
        end
        reset = 1'b0;
    endtask

    task automatic resetRecovery();
        applyReset();
        driveIssued(makeInst(OP_ARITH, randReg(), randReg(), randReg()), '0, '0,
            "first issue after reset");
        drainWriters();
    endtask

    task automatic forwardPaths();
        regIdx_t   r;
        regIdx_t   q;
        regIdx_t   x;
        instWord_t reader;
        r = randReg();
        q = pickOther(r, r);
        x = pickOther(r, q);
        // reads r through field B only
        reader = makeInst(OP_ARITH, x, r, x);
        // alu writer with the reader right behind it
        driveIssued(makeInst(OP_ARITH, q, q, r), '0, '0, "alu writer");
        driveIssued(reader, '0, forwardCode(1'b0, WB_ALU), "alu decode-slot reader");
        drainWriters();
        // one independent instruction in between
        driveIssued(makeInst(OP_ARITH, q, q, r), '0, '0, "alu writer");
        driveIssued(makeInst(OP_ARITH, q, q, q), '0, '0, "independent");
        driveIssued(reader, '0, forwardCode(1'b1, WB_ALU), "alu execute-slot reader");
        drainWriters();
        // lbi writes rs from the immediate
        driveIssued(makeInst(OP_LBI, r, q, x), '0, '0, "lbi writer");
        driveIssued(reader, '0, forwardCode(1'b0, WB_IMM), "lbi decode-slot reader");
        drainWriters();
        driveIssued(makeInst(OP_LBI, r, q, x), '0, '0, "lbi writer");
        driveIssued(makeInst(OP_ARITH, q, q, q), '0, '0, "independent");
        driveIssued(reader, '0, forwardCode(1'b1, WB_IMM), "lbi execute-slot reader");
        drainWriters();
    endtask

    task automatic loadUseStalls();
        regIdx_t   r;
        regIdx_t   q;
        regIdx_t   x;
        instWord_t reader;
        r = randReg();
        q = pickOther(r, r);
        x = pickOther(r, q);
        reader = makeInst(OP_ARITH, x, r, x);
        // load writes field B from memory
        driveIssued(makeInst(OP_LD, q, r, 3'd0), '0, '0, "load");
        holdStalled(reader, '0, '0, "load-use stall");
        driveIssued(reader, '0, forwardCode(1'b1, WB_MEM), "reader after load");
        drainWriters();
        // writer ends up in the memory slot when the reader arrives
        driveIssued(makeInst(OP_ARITH, q, q, r), '0, '0, "writer");
        driveIssued(makeInst(OP_ARITH, q, q, q), '0, '0, "first independent");
        driveIssued(makeInst(OP_ARITH, q, q, q), forwardCode(1'b0, WB_ALU),
            forwardCode(1'b0, WB_ALU), "second independent");
        holdStalled(reader, '0, '0, "memory-slot stall");
        driveIssued(reader, '0, '0, "reader after memory-slot stall");
        drainWriters();
    endtask

    task automatic controlShadow();
        regIdx_t   x;
        instWord_t held;
        instWord_t reader;
        x = pickOther(LINK_REG, LINK_REG);
        held = makeInst(OP_ARITH, x, x, x);
        reader = makeInst(OP_ARITH, x, LINK_REG, x);
        // beqz style branch while fetch holds the next word
        driveIssued(makeInst({PFX_BRANCH, 2'b00}, x, 3'd0, 3'd0), '0, '0, "branch");
        repeat (SHADOW_CYCLES) begin
            holdStalled(held, '0, '0, "branch shadow");
        end
        driveIssued(held, '0, '0, "held word after branch");
        drainWriters();
        // jal link write walks through the record during the shadow
        driveIssued(makeInst({PFX_JUMP, 2'b10}, x, x, x), '0, '0, "jal");
        holdStalled(reader, '0, forwardCode(1'b0, WB_LINK), "link in decode slot");
        holdStalled(reader, '0, forwardCode(1'b1, WB_LINK), "link in execute slot");
        holdStalled(reader, '0, '0, "link in memory slot");
        holdStalled(reader, '0, '0, "link retired");
        driveIssued(reader, '0, '0, "link reader after shadow");
        drainWriters();
    endtask

    task automatic haltLock();
        driveIssued(makeInst(OP_HALT, 3'd0, 3'd0, 3'd0), '0, '0, "halt");
        // record is empty so any word gives zero codes
        repeat (6) begin
            holdStalled(randWord(), '0, '0, "after halt");
        end
        applyReset();
        driveIssued(makeInst(OP_ARITH, randReg(), randReg(), randReg()), '0, '0,
            "issue after halt and reset");
    endtask

    initial begin
        seed = 32'h8e0;
        reset = 1'b1;
        fetchInst = NOP_INST;
        @(negedge clk);
        resetRecovery();
        forwardPaths();
        loadUseStalls();
        controlShadow();
        haltLock();
        $display("All tests passed");
        $finish;
    end

endmodule
